// ==== verilog/addrgen_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Vector memory address generator package
// Bus and page geometry, width types, instruction encodings and
// the records passed between the pipeline stages
//////////////////////////////////////////////////////////////////////

package addrgen_pkg;

  // Bus and page geometry
  localparam int unsigned ADDR_W      = 32;
  localparam int unsigned VL_W        = 16;
  localparam int unsigned BUS_BYTES   = 8;
  localparam int unsigned BUS_SIZE    = 3;
  localparam int unsigned PAGE_BITS   = 12;
  localparam int unsigned MAX_BEATS   = 256;
  localparam int unsigned QUEUE_DEPTH = 4;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [VL_W-1:0]   vlen_t;
  typedef logic [31:0]       stride_t;
  // Element width as log2 of bytes
  typedef logic [1:0]        ew_t;
  // AXI len encoding, beats minus one
  typedef logic [7:0]        beats_t;
  typedef logic [2:0]        size_t;

  typedef enum logic [1:0] {
    OP_VLE,
    OP_VSE,
    OP_VLSE,
    OP_VSSE
  } mem_op_e;

  typedef struct packed {
    mem_op_e op;
    addr_t   base;
    vlen_t   vl;
    stride_t stride;
    ew_t     ew;
  } mem_req_t;

  typedef struct packed {
    addr_t   addr;
    vlen_t   count;
    stride_t stride;
    ew_t     ew;
    logic    is_load;
    logic    is_burst;
  } job_t;

  typedef struct packed {
    addr_t  addr;
    beats_t beats;
    size_t  size;
    logic   is_load;
    logic   last;
  } burst_cmd_t;

  // INCR burst type and cache bits are implied
  typedef struct packed {
    addr_t  addr;
    beats_t beats;
    size_t  size;
  } ax_t;

  typedef struct packed {
    addr_t  addr;
    beats_t beats;
    size_t  size;
    logic   is_load;
  } ls_cmd_t;

endpackage

// ==== verilog/vmem_req_decode.sv ====
//////////////////////////////////////////////////////////////////////
// Vector memory request decode
// Latches one load/store instruction, checks the base address
// against the element width and hands a job to the burst planner.
// Acknowledges once the last request of the job is issued
//////////////////////////////////////////////////////////////////////

module vmem_req_decode (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  addrgen_pkg::mem_req_t mem_req_i,
  input  logic                  mem_req_valid_i,
  input  logic                  job_done_i,
  output addrgen_pkg::job_t     job_o,
  output logic                  job_valid_o,
  output logic                  ack_o,
  output logic                  error_o
);

  typedef enum logic [1:0] {
    IDLE,
    CHECK,
    BUSY
  } state_e;

  state_e                state_q;
  addrgen_pkg::mem_req_t req_q;
  logic                  misaligned;
  logic                  is_unit;
  logic                  is_load;

  // Any base bit below the element width is an error
  assign misaligned = |(req_q.base & addrgen_pkg::addr_t'((4'd1 << req_q.ew) - 4'd1));

  assign is_unit = (req_q.op == addrgen_pkg::OP_VLE) || (req_q.op == addrgen_pkg::OP_VSE);
  assign is_load = (req_q.op == addrgen_pkg::OP_VLE) || (req_q.op == addrgen_pkg::OP_VLSE);

  // Job content is stable from the latch until the ack
  assign job_o.addr     = req_q.base;
  assign job_o.count    = req_q.vl;
  assign job_o.stride   = req_q.stride;
  assign job_o.ew       = req_q.ew;
  assign job_o.is_load  = is_load;
  assign job_o.is_burst = is_unit;

  // Instruction register
  always_ff @(posedge clk_i) begin
    if (mem_req_valid_i && (state_q == IDLE)) begin
      req_q <= mem_req_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      job_valid_o <= 1'b0;
      ack_o       <= 1'b0;
      error_o     <= 1'b0;
    end else begin
      // Outputs are single-cycle pulses
      job_valid_o <= 1'b0;
      ack_o       <= 1'b0;
      error_o     <= 1'b0;
      case (state_q)
        IDLE: if (mem_req_valid_i) state_q <= CHECK;
        CHECK: begin
          if (misaligned) begin
            ack_o   <= 1'b1;
            error_o <= 1'b1;
            state_q <= IDLE;
          end else begin
            job_valid_o <= 1'b1;
            state_q     <= BUSY;
          end
        end
        BUSY: begin
          // Last request handed to AXI
          if (job_done_i) begin
            ack_o   <= 1'b1;
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // The sequencer only strobes between instructions
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_valid_i |-> (state_q == IDLE));

endmodule

// ==== verilog/burst_planner.sv ====
//////////////////////////////////////////////////////////////////////
// Burst planner
// Splits a job into AXI requests. Unit stride becomes INCR bursts
// bounded by the 4 KiB page and 256 beats, strided access becomes
// one single-beat request per element
//////////////////////////////////////////////////////////////////////

module burst_planner (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  addrgen_pkg::job_t       job_i,
  input  logic                    job_valid_i,
  output addrgen_pkg::burst_cmd_t burst_o,
  output logic                    burst_valid_o,
  input  logic                    burst_ready_i
);

  localparam int unsigned AW = addrgen_pkg::ADDR_W;
  localparam int unsigned BS = addrgen_pkg::BUS_SIZE;
  localparam int unsigned PB = addrgen_pkg::PAGE_BITS;

  addrgen_pkg::job_t       job_q, cur, job_nxt;
  addrgen_pkg::burst_cmd_t burst_q, cmd_nxt;
  logic                    burst_valid_q;
  logic                    gen;
  addrgen_pkg::addr_t      bytes, last_byte, start_al, cap, page_end, end_addr;
  addrgen_pkg::addr_t      span, consumed, burst_end;

  always_comb begin
    // A new job is planned in its arrival cycle
    cur = job_valid_i ? job_i : job_q;

    // Unit stride window
    bytes     = addrgen_pkg::addr_t'(cur.count) << cur.ew;
    last_byte = cur.addr + bytes - 1'b1;
    start_al  = {cur.addr[AW-1:BS], {BS{1'b0}}};
    end_addr  = {last_byte[AW-1:BS], {BS{1'b1}}};
    // Cap at 256 beats
    cap = start_al + addrgen_pkg::addr_t'(addrgen_pkg::MAX_BEATS * addrgen_pkg::BUS_BYTES - 1);
    if (end_addr > cap) end_addr = cap;
    // Cap at the end of the start page
    page_end = {cur.addr[AW-1:PB], {PB{1'b1}}};
    if (end_addr > page_end) end_addr = page_end;
    span     = end_addr - start_al;
    consumed = (end_addr - cur.addr + 1'b1) >> cur.ew;

    job_nxt         = cur;
    cmd_nxt.addr    = cur.addr;
    cmd_nxt.is_load = cur.is_load;
    if (cur.is_burst) begin
      cmd_nxt.beats = span[BS +: 8];
      cmd_nxt.size  = addrgen_pkg::size_t'(addrgen_pkg::BUS_SIZE);
      job_nxt.addr  = end_addr + 1'b1;
      // Saturate the element count at zero
      if (addrgen_pkg::addr_t'(cur.count) > consumed) begin
        job_nxt.count = cur.count - addrgen_pkg::vlen_t'(consumed);
      end else begin
        job_nxt.count = '0;
      end
    end else begin
      // One element per request, then step by the stride
      cmd_nxt.beats = '0;
      cmd_nxt.size  = addrgen_pkg::size_t'(cur.ew);
      job_nxt.addr  = cur.addr + cur.stride;
      job_nxt.count = cur.count - 1'b1;
    end
    cmd_nxt.last = (job_nxt.count == '0);
  end

  // Output register refills in the cycle it is consumed
  assign gen = (cur.count != '0) && (!burst_valid_q || burst_ready_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      job_q         <= '0;
      burst_valid_q <= 1'b0;
    end else if (gen) begin
      job_q         <= job_nxt;
      burst_valid_q <= 1'b1;
    end else if (burst_ready_i) begin
      burst_valid_q <= 1'b0;
    end
  end

  // Burst payload
  always_ff @(posedge clk_i) begin
    if (gen) begin
      burst_q <= cmd_nxt;
    end
  end

  assign burst_o       = burst_q;
  assign burst_valid_o = burst_valid_q;

  // Last byte covered by the registered request
  assign burst_end = {burst_q.addr[AW-1:BS], {BS{1'b0}}}
                   + ((addrgen_pkg::addr_t'(burst_q.beats) + 1'b1) << BS) - 1'b1;

  // No request may leave its 4 KiB page
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    burst_valid_o |-> (burst_q.addr[AW-1:PB] == burst_end[AW-1:PB]));

endmodule

// ==== verilog/ax_issue.sv ====
//////////////////////////////////////////////////////////////////////
// AXI address channel issue
// Holds one planned request, drives AR or AW and pushes the matching
// command to the load/store queue on the handshake. A request waits
// while the queue still holds commands of the other direction
//////////////////////////////////////////////////////////////////////

module ax_issue (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  addrgen_pkg::burst_cmd_t burst_i,
  input  logic                    burst_valid_i,
  output logic                    burst_ready_o,
  output addrgen_pkg::ax_t        ar_o,
  output logic                    ar_valid_o,
  input  logic                    ar_ready_i,
  output addrgen_pkg::ax_t        aw_o,
  output logic                    aw_valid_o,
  input  logic                    aw_ready_i,
  output logic                    q_push_o,
  output addrgen_pkg::ls_cmd_t    q_cmd_o,
  input  logic                    q_full_i,
  input  logic                    q_empty_i,
  input  logic                    q_head_is_load_i,
  output logic                    job_done_o
);

  addrgen_pkg::burst_cmd_t cmd_q;
  logic                    full_q;
  logic                    dir_ok;
  logic                    send;
  logic                    ax_hs;

  // Same direction as the queued commands, or nothing queued
  assign dir_ok = q_empty_i || (q_head_is_load_i == cmd_q.is_load);
  assign send   = full_q && dir_ok && !q_full_i;

  assign ar_valid_o = send && cmd_q.is_load;
  assign aw_valid_o = send && !cmd_q.is_load;
  assign ar_o       = '{addr: cmd_q.addr, beats: cmd_q.beats, size: cmd_q.size};
  assign aw_o       = '{addr: cmd_q.addr, beats: cmd_q.beats, size: cmd_q.size};

  assign ax_hs = (ar_valid_o && ar_ready_i) || (aw_valid_o && aw_ready_i);

  // Queue push with the AXI handshake
  assign q_push_o = ax_hs;
  assign q_cmd_o  = '{addr: cmd_q.addr, beats: cmd_q.beats, size: cmd_q.size,
                      is_load: cmd_q.is_load};

  assign job_done_o = ax_hs && cmd_q.last;

  // Slot frees and refills in the same cycle
  assign burst_ready_o = !full_q || ax_hs;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (burst_valid_i && burst_ready_o) begin
      full_q <= 1'b1;
    end else if (ax_hs) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (burst_valid_i && burst_ready_o) begin
      cmd_q <= burst_i;
    end
  end

  // Pending requests hold until accepted
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o));
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_o));

endmodule

// ==== verilog/ls_cmd_queue.sv ====
//////////////////////////////////////////////////////////////////////
// Load/store command queue
// Circular FIFO of issued requests, popped by the load/store units
//////////////////////////////////////////////////////////////////////

module ls_cmd_queue (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 push_i,
  input  addrgen_pkg::ls_cmd_t cmd_i,
  output logic                 full_o,
  output logic                 empty_o,
  output addrgen_pkg::ls_cmd_t head_o,
  input  logic                 pop_i
);

  localparam int unsigned PTR_W = $clog2(addrgen_pkg::QUEUE_DEPTH);

  addrgen_pkg::ls_cmd_t mem_q [addrgen_pkg::QUEUE_DEPTH];
  logic [PTR_W-1:0]     wptr_q, rptr_q;
  logic [PTR_W:0]       cnt_q;

  assign full_o  = (cnt_q == (PTR_W + 1)'(addrgen_pkg::QUEUE_DEPTH));
  assign empty_o = (cnt_q == '0);
  assign head_o  = mem_q[rptr_q];

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wptr_q] <= cmd_i;
    end
  end

  // Pointers wrap with the power-of-two depth
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q  <= '0;
    end else begin
      if (push_i) wptr_q <= wptr_q + 1'b1;
      if (pop_i)  rptr_q <= rptr_q + 1'b1;
      cnt_q <= cnt_q + (PTR_W + 1)'(push_i) - (PTR_W + 1)'(pop_i);
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni) push_i |-> !full_o);
  assert property (@(posedge clk_i) disable iff (!rst_ni) pop_i |-> !empty_o);

endmodule

// ==== verilog/vmem_addrgen.sv ====
//////////////////////////////////////////////////////////////////////
// Vector memory address generator top level
// Decode, burst planning and AXI issue in a pipeline, with the
// load/store command queue next to the issue stage
//////////////////////////////////////////////////////////////////////

module vmem_addrgen (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  addrgen_pkg::mem_req_t mem_req_i,
  input  logic                  mem_req_valid_i,
  output logic                  ack_o,
  output logic                  error_o,
  output addrgen_pkg::ax_t      ar_o,
  output logic                  ar_valid_o,
  input  logic                  ar_ready_i,
  output addrgen_pkg::ax_t      aw_o,
  output logic                  aw_valid_o,
  input  logic                  aw_ready_i,
  output addrgen_pkg::ls_cmd_t  ls_cmd_o,
  output logic                  ls_cmd_valid_o,
  input  logic                  ls_pop_i
);

  addrgen_pkg::job_t       job;
  logic                    job_valid, job_done;
  addrgen_pkg::burst_cmd_t burst;
  logic                    burst_valid, burst_ready;
  addrgen_pkg::ls_cmd_t    q_cmd;
  logic                    q_push, q_full, q_empty;

  vmem_req_decode i_decode (
    .clk_i, .rst_ni, .mem_req_i, .mem_req_valid_i,
    .job_done_i (job_done),
    .job_o      (job),
    .job_valid_o(job_valid),
    .ack_o, .error_o
  );

  burst_planner i_planner (
    .clk_i, .rst_ni,
    .job_i        (job),
    .job_valid_i  (job_valid),
    .burst_o      (burst),
    .burst_valid_o(burst_valid),
    .burst_ready_i(burst_ready)
  );

  // Head direction feeds back for the channel ordering
  ax_issue i_issue (
    .clk_i, .rst_ni,
    .burst_i(burst), .burst_valid_i(burst_valid), .burst_ready_o(burst_ready),
    .ar_o, .ar_valid_o, .ar_ready_i, .aw_o, .aw_valid_o, .aw_ready_i,
    .q_push_o(q_push), .q_cmd_o(q_cmd), .q_full_i(q_full), .q_empty_i(q_empty),
    .q_head_is_load_i(ls_cmd_o.is_load),
    .job_done_o(job_done)
  );

  ls_cmd_queue i_queue (
    .clk_i, .rst_ni,
    .push_i(q_push), .cmd_i(q_cmd), .full_o(q_full), .empty_o(q_empty),
    .head_o(ls_cmd_o), .pop_i(ls_pop_i)
  );

  assign ls_cmd_valid_o = !q_empty;

endmodule

// ==== test/addrgen_tests.svh ====
//////////////////////////////////////////////////////////////////////
// Directed tests for the vector memory address generator
//////////////////////////////////////////////////////////////////////

`ifndef ADDRGEN_TESTS_SVH
`define ADDRGEN_TESTS_SVH

// Twenty words from 0x40 fill ten beats of one AR burst
task automatic unit_load_in_page();
  int n;
  run_job("unit_load", '{op: addrgen_pkg::OP_VLE, base: 32'h1000_0040, vl: 16'd20,
          stride: 32'd0, ew: 2'd2}, 1'b0, 0, 1'b0, n);
  compare_value("unit_load bursts", 1, n);
  drain_queue("unit_load");
endtask

// 256 bytes from 0xfc0 split at the page into 8 and 24 beats
task automatic page_cross_store();
  int n;
  run_job("page_cross", '{op: addrgen_pkg::OP_VSE, base: 32'h2000_0fc0, vl: 16'd32,
          stride: 32'd0, ew: 2'd3}, 1'b0, 0, 1'b0, n);
  compare_value("page_cross bursts", 2, n);
  drain_queue("page_cross");
endtask

// 600 doublewords give two full 256-beat bursts then 88 beats
task automatic long_load_stalled();
  int n;
  run_job("long_load", '{op: addrgen_pkg::OP_VLE, base: 32'h3000_0000, vl: 16'd600,
          stride: 32'd0, ew: 2'd3}, 1'b1, 0, 1'b0, n);
  compare_value("long_load bursts", 3, n);
  drain_queue("long_load");
endtask

// Five words with one single-beat AW each
task automatic strided_store();
  int n;
  run_job("strided", '{op: addrgen_pkg::OP_VSSE, base: 32'h4000_0010, vl: 16'd5,
          stride: 32'h24, ew: 2'd2}, 1'b0, 0, 1'b0, n);
  compare_value("strided requests", 5, n);
  drain_queue("strided");
endtask

task automatic misaligned_base();
  int n;
  run_job("misaligned", '{op: addrgen_pkg::OP_VLE, base: 32'h5000_0006, vl: 16'd4,
          stride: 32'd0, ew: 2'd2}, 1'b0, 0, 1'b1, n);
  compare_value("misaligned requests", 0, n);
  compare_value("misaligned queue", 0, ls_cmd_valid);
endtask

// Store command stays queued, so the load waits for the pops
task automatic store_then_load();
  int n;
  run_job("store_first", '{op: addrgen_pkg::OP_VSE, base: 32'h6000_0000, vl: 16'd8,
          stride: 32'd0, ew: 2'd3}, 1'b0, 100000, 1'b0, n);
  compare_value("store_first bursts", 1, n);
  compare_value("store_first queued", 1, ls_cmd_valid);
  run_job("load_after", '{op: addrgen_pkg::OP_VLE, base: 32'h6000_1000, vl: 16'd16,
          stride: 32'd0, ew: 2'd2}, 1'b0, 10, 1'b0, n);
  compare_value("load_after bursts", 1, n);
  drain_queue("load_after");
endtask

`endif

// ==== test/addrgen_tb.sv ====
//////////////////////////////////////////////////////////////////////
// Vector memory address generator testbench
// Clock, reset, DUT, reference burst model and AXI/queue monitors
//////////////////////////////////////////////////////////////////////

module addrgen_tb;
  timeunit 1ns;
  timeprecision 100ps;

  logic                  clk;
  logic                  rst_n;
  addrgen_pkg::mem_req_t mem_req;
  logic                  mem_req_valid, ack, error;
  addrgen_pkg::ax_t      ar, aw;
  logic                  ar_valid, ar_ready, aw_valid, aw_ready;
  addrgen_pkg::ls_cmd_t  ls_cmd;
  logic                  ls_cmd_valid, ls_pop;

  integer                seed = 32'hbc8d;
  // Expected AXI requests of the running job, and queue contents in order
  addrgen_pkg::ax_t      exp_ax[$];
  addrgen_pkg::ls_cmd_t  exp_q[$];

  vmem_addrgen uut (
    .clk_i(clk), .rst_ni(rst_n), .mem_req_i(mem_req), .mem_req_valid_i(mem_req_valid),
    .ack_o(ack), .error_o(error),
    .ar_o(ar), .ar_valid_o(ar_valid), .ar_ready_i(ar_ready),
    .aw_o(aw), .aw_valid_o(aw_valid), .aw_ready_i(aw_ready),
    .ls_cmd_o(ls_cmd), .ls_cmd_valid_o(ls_cmd_valid), .ls_pop_i(ls_pop)
  );

  always #5 clk = ~clk;

  task automatic stop_on_failure(input string what);
    $display("%s", what);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic compare_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
    if (expected !== actual) begin
      $display("Error: %s expected %0h actual %0h", name, expected, actual);
      stop_on_failure("Mismatch between expected and actual value");
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Reference burst list built from the page and length rules
  ////////////////////////////////////////////////////////////////////
  task automatic plan_bursts(input addrgen_pkg::mem_req_t req);
    longint unsigned  addr, last, st, fin, count, used, eb;
    addrgen_pkg::ax_t ax;
    bit               unit;
    exp_ax.delete();
    unit  = (req.op == addrgen_pkg::OP_VLE) || (req.op == addrgen_pkg::OP_VSE);
    eb    = 1 << req.ew;
    addr  = req.base;
    count = req.vl;
    // Misaligned base issues nothing
    if (addr % eb != 0) return;
    while (count > 0) begin
      if (unit) begin
        st   = addr - addr % 8;
        last = addr + count * eb - 1;
        fin  = last - last % 8 + 7;
        if (fin > st + 2047) fin = st + 2047;
        if (fin > (addr | 64'hfff)) fin = addr | 64'hfff;
        ax    = '{addr: addr[31:0], beats: 8'((fin - st) / 8), size: 3'd3};
        used  = (fin - addr + 1) / eb;
        count = (count > used) ? count - used : 0;
        addr  = fin + 1;
      end else begin
        ax    = '{addr: addr[31:0], beats: 8'd0, size: 3'(req.ew)};
        addr  = addr + req.stride;
        count = count - 1;
      end
      exp_ax.push_back(ax);
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Job runner strobes once and then watches AR/AW and pops until ack
  ////////////////////////////////////////////////////////////////////
  task automatic run_job(input string name, input addrgen_pkg::mem_req_t req,
                         input bit stall, input int pop_start, input bit exp_err,
                         output int n_hs);
    int               cyc;
    bit               done, exp_load, stalled;
    addrgen_pkg::ax_t held, got, want;
    logic [31:0]      rnd;
    plan_bursts(req);
    exp_load = (req.op == addrgen_pkg::OP_VLE) || (req.op == addrgen_pkg::OP_VLSE);
    stalled  = 1'b0;
    done     = 1'b0;
    cyc      = 0;
    n_hs     = 0;
    @(posedge clk);
    #1;
    mem_req       = req;
    mem_req_valid = 1'b1;
    @(posedge clk);
    #1;
    mem_req_valid = 1'b0;
    while (!done) begin
      @(posedge clk);
      #1;
      rnd      = $random(seed);
      ar_ready = stall ? rnd[0] : 1'b1;
      aw_ready = stall ? rnd[1] : 1'b1;
      ls_pop   = (cyc >= pop_start) && ls_cmd_valid;
      #1;
      got = exp_load ? ar : aw;
      // A request refused by the slave holds until taken
      if (stalled) begin
        compare_value({name, " stall"}, {1'b1, held},
                      {(exp_load ? ar_valid : aw_valid), got});
      end
      stalled = exp_load ? (ar_valid && !ar_ready) : (aw_valid && !aw_ready);
      held    = got;
      compare_value({name, " direction"}, 0, exp_load ? aw_valid : ar_valid);
      // Queue head of the other direction blocks the channel
      if (ls_cmd_valid && (ls_cmd.is_load != exp_load)) begin
        compare_value({name, " order"}, 0, ar_valid | aw_valid);
      end
      if (exp_ax.size() == 0) begin
        compare_value({name, " extra request"}, 0, ar_valid | aw_valid);
      end else if ((ar_valid && ar_ready) || (aw_valid && aw_ready)) begin
        want = exp_ax.pop_front();
        compare_value(name, want, got);
        exp_q.push_back('{addr: want.addr, beats: want.beats, size: want.size,
                          is_load: exp_load});
        n_hs++;
      end
      if (ls_pop) compare_value({name, " pop"}, exp_q.pop_front(), ls_cmd);
      if (ack) begin
        compare_value({name, " error"}, exp_err, error);
        done = 1'b1;
      end
      cyc++;
      if (cyc > 2000) stop_on_failure({"Timeout: no acknowledge for ", name});
    end
    compare_value({name, " missing requests"}, 0, exp_ax.size());
  endtask

  // Pop every remaining queue entry and compare it
  task automatic drain_queue(input string name);
    int cyc;
    cyc = 0;
    do begin
      @(posedge clk);
      #1;
      ls_pop = ls_cmd_valid;
      #1;
      if (ls_pop) compare_value({name, " pop"}, exp_q.pop_front(), ls_cmd);
      cyc++;
      if (cyc > 50) stop_on_failure({"Timeout: queue never drained in ", name});
    end while (ls_pop);
    compare_value({name, " queue left"}, 0, exp_q.size());
  endtask

  `include "addrgen_tests.svh"

  initial begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    mem_req       = '0;
    mem_req_valid = 1'b0;
    ar_ready      = 1'b0;
    aw_ready      = 1'b0;
    ls_pop        = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    compare_value("reset outputs", 0, {ack, error, ar_valid, aw_valid, ls_cmd_valid});
    unit_load_in_page();
    page_cross_store();
    long_load_stalled();
    strided_store();
    misaligned_base();
    store_then_load();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+test
verilog/addrgen_pkg.sv
verilog/vmem_req_decode.sv
verilog/burst_planner.sv
verilog/ax_issue.sv
verilog/ls_cmd_queue.sv
verilog/vmem_addrgen.sv
test/addrgen_tb.sv
